/* hw/l2_pkg.sv */
`default_nettype none

package l2_pkg;

	// Cache geometry
	localparam int WAYS       = 2;
	localparam int SETS       = 8;
	localparam int BEATS      = 4;
	localparam int BEAT_BYTES = 8;
	// 32-byte line split into offset, set index and tag
	localparam int OFFSET_W   = 5;
	localparam int SET_W      = 3;
	localparam int TAG_W      = 32 - OFFSET_W - SET_W;

	typedef logic [31:0]                 addr_t;
	typedef logic [BEAT_BYTES*8-1:0]     data_t;
	typedef logic [TAG_W-1:0]            tag_t;
	typedef logic [SET_W-1:0]            set_t;
	typedef logic [$clog2(BEATS)-1:0]    beat_t;
	typedef logic [$clog2(WAYS)-1:0]     way_t;

	// Controller states
	typedef enum logic [2:0] {
		FREE,
		CHECK,
		REFILL,
		RESP_I,
		RESP_D,
		FENCE
	} ctrl_state_t;

endpackage

`default_nettype wire

/* hw/l2_ctrl.sv */
`default_nettype none

module l2_ctrl (
	input  wire                clk,
	input  wire                rst_n,
	input  wire l2_pkg::addr_t il1_araddr,
	input  wire                il1_arvalid,
	input  wire l2_pkg::addr_t dl1_araddr,
	input  wire                dl1_arvalid,
	input  wire                fence,
	input  wire                hit,
	input  wire l2_pkg::way_t  hit_way,
	input  wire                refill_done,
	input  wire l2_pkg::beat_t il1_beat,
	input  wire l2_pkg::beat_t dl1_beat,
	input  wire                il1_end,
	input  wire                dl1_end,
	output logic               il1_arready,
	output logic               dl1_arready,
	output l2_pkg::addr_t      lookup_addr,
	output logic               allocate,
	output logic               invalidate_all,
	output logic               refill_start,
	output l2_pkg::way_t       rd_way,
	output l2_pkg::set_t       rd_set,
	output l2_pkg::beat_t      rd_beat,
	output logic               il1_start,
	output logic               dl1_start,
	output logic               fence_done
);
	import l2_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	addr_t       addr_q;
	logic        sel_d;
	logic        take_req;

	// A request is taken only when no fence is pending
	assign take_req = (state == FREE) && !fence && (il1_arvalid || dl1_arvalid);

	always_comb begin
		state_nxt = state;
		case (state)
			FREE: begin
				if (fence) begin
					state_nxt = FENCE;
				end else if (take_req) begin
					state_nxt = CHECK;
				end
			end
			CHECK: begin
				// After a refill this check always hits
				if (!hit) begin
					state_nxt = REFILL;
				end else if (sel_d) begin
					state_nxt = RESP_D;
				end else begin
					state_nxt = RESP_I;
				end
			end
			REFILL: begin
				if (refill_done) begin
					state_nxt = CHECK;
				end
			end
			RESP_I: begin
				if (il1_end) begin
					state_nxt = FREE;
				end
			end
			RESP_D: begin
				if (dl1_end) begin
					state_nxt = FREE;
				end
			end
			FENCE: state_nxt = FREE;
			default: state_nxt = FREE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= FREE;
			sel_d      <= 1'b0;
			fence_done <= 1'b0;
		end else begin
			state      <= state_nxt;
			// Done one cycle after the invalidate lands
			fence_done <= (state == FENCE);
			if (take_req) begin
				// Instruction port wins a tie
				sel_d <= !il1_arvalid;
			end
		end
	end

	// Requested address locked for the whole transaction
	always_ff @(posedge clk) begin
		if (take_req) begin
			addr_q <= il1_arvalid ? il1_araddr : dl1_araddr;
		end
	end

	assign lookup_addr = addr_q;

	// Accept and start the response together on a hit
	assign il1_arready = (state == CHECK) && hit && !sel_d;
	assign dl1_arready = (state == CHECK) && hit && sel_d;
	assign il1_start   = il1_arready;
	assign dl1_start   = dl1_arready;

	// Miss allocates a way and kicks off the memory read
	assign allocate       = (state == CHECK) && !hit;
	assign refill_start   = allocate;
	assign invalidate_all = (state == FENCE);

	// Read beat follows the counter of whichever port is answering
	assign rd_way  = hit_way;
	assign rd_set  = addr_q[OFFSET_W +: SET_W];
	assign rd_beat = (state == RESP_D) ? dl1_beat : il1_beat;

endmodule

`default_nettype wire

/* hw/l2_tag_array.sv */
`default_nettype none

module l2_tag_array (
	input  wire                clk,
	input  wire                rst_n,
	input  wire l2_pkg::addr_t lookup_addr,
	input  wire                allocate,
	input  wire                invalidate_all,
	output logic               hit,
	output l2_pkg::way_t       hit_way,
	output l2_pkg::way_t       fill_way
);
	import l2_pkg::*;

	tag_t            tags [SETS][WAYS];
	logic [WAYS-1:0] valid [SETS];
	logic [15:0]     lfsr;
	tag_t            look_tag;
	set_t            look_set;
	way_t            victim;

	assign look_tag = lookup_addr[31 -: TAG_W];
	assign look_set = lookup_addr[OFFSET_W +: SET_W];

	// Compare every way of the selected set
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid[look_set][w] && (tags[look_set][w] == look_tag)) begin
				hit     = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	// Lowest invalid way first
	// a full set falls back to the random pick
	always_comb begin
		victim = lfsr[$bits(way_t)-1:0];
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!valid[look_set][w]) begin
				victim = way_t'(w);
			end
		end
	end

	// Free-running 16-bit LFSR, taps 16 14 13 11
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr <= 16'hace1;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '{default: '0};
		end else if (invalidate_all) begin
			valid <= '{default: '0};
		end else if (allocate) begin
			valid[look_set][victim] <= 1'b1;
		end
	end

	// New tag goes in at allocation, way kept for the refill writes
	always_ff @(posedge clk) begin
		if (allocate) begin
			tags[look_set][victim] <= look_tag;
			fill_way               <= victim;
		end
	end

endmodule

`default_nettype wire

/* hw/l2_data_array.sv */
`default_nettype none

module l2_data_array (
	input  wire                clk,
	input  wire                wr_en,
	input  wire l2_pkg::way_t  wr_way,
	input  wire l2_pkg::set_t  wr_set,
	input  wire l2_pkg::beat_t wr_beat,
	input  wire l2_pkg::data_t wr_data,
	input  wire l2_pkg::way_t  rd_way,
	input  wire l2_pkg::set_t  rd_set,
	input  wire l2_pkg::beat_t rd_beat,
	output l2_pkg::data_t      rd_data
);
	import l2_pkg::*;

	// One 64-bit beat per entry
	data_t mem [WAYS][SETS][BEATS];

	// Single write port fed by the refill engine
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_way][wr_set][wr_beat] <= wr_data;
		end
	end

	// Asynchronous read of the beat being presented
	assign rd_data = mem[rd_way][rd_set][rd_beat];

endmodule

`default_nettype wire

/* hw/l2_refill.sv */
`default_nettype none

module l2_refill (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                start,
	input  wire l2_pkg::addr_t line_addr,
	input  wire l2_pkg::way_t  fill_way,
	input  wire                mem_arready,
	input  wire l2_pkg::data_t mem_rdata,
	input  wire                mem_rvalid,
	input  wire                mem_rlast,
	output l2_pkg::addr_t      mem_araddr,
	output logic               mem_arvalid,
	output logic               mem_rready,
	output logic               wr_en,
	output l2_pkg::way_t       wr_way,
	output l2_pkg::set_t       wr_set,
	output l2_pkg::beat_t      wr_beat,
	output l2_pkg::data_t      wr_data,
	output logic               done
);
	import l2_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_arvalid <= 1'b0;
			mem_rready  <= 1'b0;
			wr_beat     <= '0;
		end else begin
			if (start) begin
				mem_arvalid <= 1'b1;
			end else if (mem_arvalid && mem_arready) begin
				// Address taken, open the data channel
				mem_arvalid <= 1'b0;
				mem_rready  <= 1'b1;
				wr_beat     <= '0;
			end
			if (wr_en) begin
				wr_beat <= wr_beat + 1'b1;
				if (mem_rlast) begin
					mem_rready <= 1'b0;
				end
			end
		end
	end

	// Line-aligned request address
	always_ff @(posedge clk) begin
		if (start) begin
			mem_araddr <= {line_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
		end
	end

	// Every accepted beat goes straight into the array
	assign wr_en   = mem_rvalid && mem_rready;
	assign wr_way  = fill_way;
	assign wr_set  = mem_araddr[OFFSET_W +: SET_W];
	assign wr_data = mem_rdata;
	assign done    = wr_en && mem_rlast;

endmodule

`default_nettype wire

/* hw/l2_read_port.sv */
`default_nettype none

module l2_read_port (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           start,
	input  wire           rready,
	output logic          rvalid,
	output logic          rlast,
	output l2_pkg::beat_t beat,
	output logic          resp_end
);
	import l2_pkg::*;

	// Beat index doubles as the data array read pointer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			beat   <= '0;
		end else if (start) begin
			rvalid <= 1'b1;
			beat   <= '0;
		end else if (rvalid && rready) begin
			beat <= beat + 1'b1;
			if (rlast) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Last flag while the final beat is on the bus
	assign rlast = rvalid && (beat == beat_t'(BEATS - 1));

	// Whole line handed over
	assign resp_end = rvalid && rready && rlast;

endmodule

`default_nettype wire

/* hw/l2_cache.sv */
`default_nettype none

module l2_cache (
	input  wire                clk,
	input  wire                rst_n,
	// Instruction side
	input  wire l2_pkg::addr_t il1_araddr,
	input  wire                il1_arvalid,
	output logic               il1_arready,
	output l2_pkg::data_t      il1_rdata,
	output logic               il1_rvalid,
	output logic               il1_rlast,
	input  wire                il1_rready,
	// Data side
	input  wire l2_pkg::addr_t dl1_araddr,
	input  wire                dl1_arvalid,
	output logic               dl1_arready,
	output l2_pkg::data_t      dl1_rdata,
	output logic               dl1_rvalid,
	output logic               dl1_rlast,
	input  wire                dl1_rready,
	// Memory read channel
	output l2_pkg::addr_t      mem_araddr,
	output logic               mem_arvalid,
	input  wire                mem_arready,
	input  wire l2_pkg::data_t mem_rdata,
	input  wire                mem_rvalid,
	input  wire                mem_rlast,
	output logic               mem_rready,
	input  wire                fence,
	output logic               fence_done
);
	import l2_pkg::*;

	// Tag lookup and allocation
	addr_t lookup_addr;
	logic  allocate;
	logic  invalidate_all;
	logic  hit;
	way_t  hit_way;
	way_t  fill_way;
	// Refill to data array
	logic  refill_start;
	logic  refill_done;
	logic  wr_en;
	way_t  wr_way;
	set_t  wr_set;
	beat_t wr_beat;
	data_t wr_data;
	// Response side
	way_t  rd_way;
	set_t  rd_set;
	beat_t rd_beat;
	data_t rd_data;
	logic  il1_start;
	logic  dl1_start;
	beat_t il1_beat;
	beat_t dl1_beat;
	logic  il1_end;
	logic  dl1_end;

	l2_ctrl i_ctrl (.*);

	l2_tag_array i_tag_array (.*);

	l2_data_array i_data_array (.*);

	l2_refill i_refill (
		.start    (refill_start),
		.line_addr(lookup_addr),
		.done     (refill_done),
		.*
	);

	l2_read_port i_il1_port (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (il1_start),
		.rready  (il1_rready),
		.rvalid  (il1_rvalid),
		.rlast   (il1_rlast),
		.beat    (il1_beat),
		.resp_end(il1_end)
	);

	l2_read_port i_dl1_port (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (dl1_start),
		.rready  (dl1_rready),
		.rvalid  (dl1_rvalid),
		.rlast   (dl1_rlast),
		.beat    (dl1_beat),
		.resp_end(dl1_end)
	);

	// Only the active port presents rvalid so both can share the read beat
	assign il1_rdata = rd_data;
	assign dl1_rdata = rd_data;

endmodule

`default_nettype wire

/* testbench/tb_l2_cache.sv */
`default_nettype none

module tb_l2_cache;
	timeunit 1ns;
	timeprecision 1ps;
	import l2_pkg::*;

	localparam int WAIT_LIMIT = 2000;

	logic  clk = 1'b0;
	logic  rst_n = 1'b0;
	addr_t il1_araddr = '0;
	logic  il1_arvalid = 1'b0;
	logic  il1_arready;
	data_t il1_rdata;
	logic  il1_rvalid;
	logic  il1_rlast;
	logic  il1_rready = 1'b0;
	addr_t dl1_araddr = '0;
	logic  dl1_arvalid = 1'b0;
	logic  dl1_arready;
	data_t dl1_rdata;
	logic  dl1_rvalid;
	logic  dl1_rlast;
	logic  dl1_rready = 1'b0;
	addr_t mem_araddr;
	logic  mem_arvalid;
	logic  mem_arready = 1'b0;
	data_t mem_rdata = '0;
	logic  mem_rvalid = 1'b0;
	logic  mem_rlast = 1'b0;
	logic  mem_rready;
	logic  fence = 1'b0;
	logic  fence_done;

	// Memory model state
	logic [31:0] rng_mem = 32'd69;
	logic        mem_busy = 1'b0;
	addr_t       mem_line = '0;
	int          next_beat = 0;
	int          refill_count = 0;
	// Requester state, index 0 is il1 and index 1 is dl1
	logic [31:0] rng_req = 32'd69;
	addr_t       exp_line [2];
	int          beat_cnt [2] = '{0, 0};
	int          done_cnt [2] = '{0, 0};
	logic        held [2] = '{1'b0, 1'b0};
	logic        held_last [2];
	data_t       held_data [2];

	l2_cache i_l2_cache (.*);

	initial begin
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Beat k of a line carries its byte address on top and the inverse below
	function automatic data_t line_beat(input addr_t line, input int k);
		addr_t a;
		a = line + addr_t'(k * BEAT_BYTES);
		return {a, ~a};
	endfunction

	function automatic addr_t line_of(input addr_t a);
		return a & ~addr_t'(BEATS * BEAT_BYTES - 1);
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			report_failure($sformatf("ERROR at %0d ns: %s expected %h, got %h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("ERROR at %0d ns: %s expected %b, got %b",
				$time, name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			report_failure($sformatf("ERROR at %0d ns: %s expected %0d, got %0d",
				$time, name, exp, act));
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			report_failure($sformatf("ERROR at %0d ns: %s expected %h, got %h",
				$time, name, exp, act));
		end
	endtask

	// Every handshake output idle while reset is held
	task automatic check_reset_outputs();
		check_flag("il1_arready", 1'b0, il1_arready);
		check_flag("il1_rvalid", 1'b0, il1_rvalid);
		check_flag("il1_rlast", 1'b0, il1_rlast);
		check_flag("dl1_arready", 1'b0, dl1_arready);
		check_flag("dl1_rvalid", 1'b0, dl1_rvalid);
		check_flag("dl1_rlast", 1'b0, dl1_rlast);
		check_flag("mem_arvalid", 1'b0, mem_arvalid);
		check_flag("mem_rready", 1'b0, mem_rready);
		check_flag("fence_done", 1'b0, fence_done);
	endtask

	// Memory answers one line at a time with random stalls on both channels
	always @(posedge clk) begin
		rng_mem = xorshift(rng_mem);
		if (rst_n) begin
			mem_arready <= !mem_busy && rng_mem[1];
			if (mem_arvalid && mem_arready) begin
				mem_busy     <= 1'b1;
				mem_line     <= mem_araddr;
				next_beat    <= 0;
				refill_count <= refill_count + 1;
			end
			// Next beat only once the channel is free
			if (!mem_rvalid || mem_rready) begin
				if (mem_busy && next_beat < BEATS && rng_mem[0]) begin
					mem_rvalid <= 1'b1;
					mem_rdata  <= line_beat(mem_line, next_beat);
					mem_rlast  <= (next_beat == BEATS - 1);
					next_beat  <= next_beat + 1;
				end else begin
					mem_rvalid <= 1'b0;
					mem_rlast  <= 1'b0;
				end
			end
			if (mem_rvalid && mem_rready && mem_rlast) begin
				mem_busy <= 1'b0;
			end
		end
	end

	task automatic watch_port(input int p, input logic rvalid, input logic rready,
			input logic rlast, input data_t rdata);
		string pfx;
		pfx = (p == 0) ? "il1" : "dl1";
		// A stalled beat stays put until taken
		if (held[p]) begin
			check_flag({pfx, "_rvalid"}, 1'b1, rvalid);
			check_flag({pfx, "_rlast"}, held_last[p], rlast);
			check_data({pfx, "_rdata"}, held_data[p], rdata);
		end
		held[p]      <= rvalid && !rready;
		held_last[p] <= rlast;
		held_data[p] <= rdata;
		if (rvalid && rready) begin
			check_data({pfx, "_rdata"}, line_beat(exp_line[p], beat_cnt[p]), rdata);
			check_flag({pfx, "_rlast"}, beat_cnt[p] == BEATS - 1, rlast);
			if (rlast) begin
				beat_cnt[p] <= 0;
				done_cnt[p] <= done_cnt[p] + 1;
			end else begin
				beat_cnt[p] <= beat_cnt[p] + 1;
			end
		end
	endtask

	// Both requesters drop rready at random
	always @(posedge clk) begin
		rng_req = xorshift(rng_req);
		il1_rready <= rng_req[2] | rng_req[9];
		dl1_rready <= rng_req[4] | rng_req[11];
		if (rst_n) begin
			watch_port(0, il1_rvalid, il1_rready, il1_rlast, il1_rdata);
			watch_port(1, dl1_rvalid, dl1_rready, dl1_rlast, dl1_rdata);
		end
	end

	task automatic run_read(input byte op, input addr_t ai, input addr_t ad,
			input int ref_i, input int ref_d);
		logic want_i;
		logic want_d;
		int   start_i;
		int   start_d;
		int   start_ref;
		int   exp_i;
		int   exp_d;
		int   waited;
		want_i      = (op == "I") || (op == "B");
		want_d      = (op == "D") || (op == "B");
		exp_i       = want_i ? ref_i : 0;
		exp_d       = want_d ? ref_d : 0;
		exp_line[0] = line_of(ai);
		exp_line[1] = line_of(ad);
		start_i     = done_cnt[0];
		start_d     = done_cnt[1];
		start_ref   = refill_count;
		waited      = 0;
		il1_araddr  <= ai;
		il1_arvalid <= want_i;
		dl1_araddr  <= ad;
		dl1_arvalid <= want_d;
		while ((want_i && done_cnt[0] == start_i) ||
				(want_d && done_cnt[1] == start_d)) begin
			@(posedge clk);
			waited++;
			if (il1_arvalid && il1_arready) begin
				il1_arvalid <= 1'b0;
			end
			if (dl1_arvalid && dl1_arready) begin
				dl1_arvalid <= 1'b0;
			end
			// Data port silent until the instruction line is through
			if (want_i && want_d && done_cnt[0] == start_i) begin
				check_flag("dl1_rvalid", 1'b0, dl1_rvalid);
			end
			if (waited > WAIT_LIMIT) begin
				if (il1_arvalid || dl1_arvalid) begin
					report_failure($sformatf("Timeout: the %s address handshake never came",
						il1_arvalid ? "il1" : "dl1"));
				end else begin
					report_failure("Timeout: the last response beat never came");
				end
			end
		end
		if (exp_i == 2 || exp_d == 2) begin
			if (refill_count - start_ref > 1) begin
				report_failure("More than one refill was requested for a single read");
			end
		end else begin
			check_count("refill requests", exp_i + exp_d, refill_count - start_ref);
			if (exp_i + exp_d == 1) begin
				check_addr("mem_araddr", line_of(exp_i == 1 ? ai : ad), mem_line);
			end
		end
	endtask

	task automatic run_fence();
		int waited;
		waited = 0;
		fence <= 1'b1;
		@(posedge clk);
		fence <= 1'b0;
		while (!fence_done) begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_failure("Timeout: fence_done never came");
			end
		end
		// Single-cycle completion pulse
		@(posedge clk);
		check_flag("fence_done", 1'b0, fence_done);
	endtask

	initial begin
		int    cases_fd;
		string text;
		byte   op;
		addr_t ai;
		addr_t ad;
		int    ref_i;
		int    ref_d;
		repeat (5) @(posedge clk);
		check_reset_outputs();
		rst_n <= 1'b1;
		cases_fd = $fopen("testbench/l2_cases.txt", "r");
		if (cases_fd == 0) begin
			report_failure("Cannot open testbench/l2_cases.txt");
		end
		while ($fgets(text, cases_fd) != 0) begin
			// Comment and blank lines skipped
			if (text.len() >= 2 && text[0] != "#") begin
				if ($sscanf(text, "%c %h %h %d %d", op, ai, ad, ref_i, ref_d) != 5) begin
					report_failure({"Malformed case line: ", text});
				end
				if (op == "F") begin
					run_fence();
				end else begin
					run_read(op, ai, ad, ref_i, ref_d);
				end
			end
		end
		$fclose(cases_fd);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/l2_cases.txt */
# Columns are op, il1 address, dl1 address, il1 refills, dl1 refills
# Op I or D reads one port, B reads both, F fences; refills of 2 allow one at most
I 00001000 00000000 1 0
I 00001018 00000000 0 0
D 00000000 00001008 0 0
D 00000000 00002040 0 1
D 00000000 00002058 0 0
B 00003080 00004100 1 1
B 00003098 00004110 0 0
I 000050a0 00000000 1 0
D 00000000 000060a8 0 1
I 000070b8 00000000 1 0
D 00000000 000050a0 0 2
I 000060b0 00000000 2 0
F 00000000 00000000 0 0
I 00001010 00000000 1 0
D 00000000 00002048 0 1
B 00003080 00003088 1 0

/* all.f */
hw/l2_pkg.sv
hw/l2_ctrl.sv
hw/l2_tag_array.sv
hw/l2_data_array.sv
hw/l2_refill.sv
hw/l2_read_port.sv
hw/l2_cache.sv
testbench/tb_l2_cache.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_l2_cache -o tb_l2_cache || exit 1
./obj_dir/tb_l2_cache > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && echo "Simulation failed" && exit 1
grep -q "Test OK" sim.log || exit 1
echo "Simulation passed"
